// ==== Makefile ====
# Verilator lint and simulation of the post-code block

VERILATOR = verilator
FLAGS     = --timing
TOP       = postTb
FILELIST  = list.f
BUILD     = obj_dir
LOG       = sim.log
PASS      = all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/postChecker.sv ====
// checker: reference model of fail flags, rotation and display, compares and counts errors
`timescale 1ns/10ps

module postChecker #(
   parameter int dwellCycles = 20
) (
   input  logic                iClk,
   input  logic                rstN,
   input  postPkg::errorCodesT errorCodes,
   input  postPkg::seqFailT    seqFail,
   input  postPkg::segPairT    display,
   output int                  valueErrors,          // wrong values seen
   output int                  stuckErrors,          // rotation stalls seen
   output int                  rounds                // model returns to idle
);

   int               mSrc;                           // model source, 0 = idle
   int               mLeft;                          // cycles left in dwell
   postPkg::segPairT mDisplay;                       // model digit registers
   bit               primed;                         // first reset edge seen
   int               mismatchRun;                    // cycles display off model

   //////////////////////////////
   // model helpers
   //////////////////////////////

   function automatic int wordWidth(int id);
      case (id)
         1: return 5;
         2: return 4;
         3: return 3;
         4, 5: return 8;
         default: return 9;
      endcase
   endfunction

   function automatic logic [8:0] rawWord(postPkg::errorCodesT c, int id);
      case (id)
         1: return 9'(c.bmc);
         2: return 9'(c.pch);
         3: return 9'(c.psu);
         4: return 9'(c.cpu0);
         5: return 9'(c.cpu1);
         default: return c.mem;
      endcase
   endfunction

   // base + lowest failed rail * stride, msb picks timer base
   function automatic logic [7:0] codeFor(postPkg::errorCodesT c, int id);
      logic [8:0] raw;
      int         w;
      int         idx;
      bit         found;
      logic [7:0] base;
      raw   = rawWord(c, id);
      w     = wordWidth(id);
      idx   = 0;
      found = 0;
      for (int b = 0; b < w - 1; b++)
      begin
         if (raw[b] && !found)
         begin
            idx   = b;
            found = 1;
         end
      end
      base = raw[w-1] ? postPkg::TimerBase[id-1] : postPkg::PgBase[id-1];
      return 8'(int'(base) + idx * int'(postPkg::CodeStride[id-1]));
   endfunction

   // lowest failing source above cur, 0 if none
   function automatic int nextFailing(postPkg::errorCodesT c, int cur);
      int nxt;
      nxt = 0;
      for (int id = 6; id > cur; id--)
      begin
         if (rawWord(c, id) != 9'd0)
         begin
            nxt = id;
         end
      end
      return nxt;
   endfunction

   //////////////////////////////
   // compare and step model
   //////////////////////////////

   initial
   begin
      valueErrors = 0;
      stuckErrors = 0;
      rounds      = 0;
      primed      = 0;
      mismatchRun = 0;
   end

   always @(posedge iClk)
   begin : modelStep
      postPkg::seqFailT expFail;
      logic [7:0]       code;
      int               nxt;
      expFail.bmc    = |errorCodes.bmc;
      expFail.pch    = |errorCodes.pch;
      expFail.psu    = |errorCodes.psu;
      expFail.cpuMem = |errorCodes.cpu0 | |errorCodes.cpu1 | |errorCodes.mem;
      if (primed)
      begin
         if (seqFail !== expFail)
         begin
            $display("Fail seqFail expected %h got %h", expFail, seqFail);
            valueErrors = valueErrors + 1;
         end
         if (display !== mDisplay)
         begin
            $display("Fail display expected %h got %h", mDisplay, display);
            valueErrors = valueErrors + 1;
            mismatchRun <= mismatchRun + 1;
            if (mismatchRun == dwellCycles)          // one report per stall
            begin
               $display("rotation stuck: display off the expected source for a whole dwell");
               stuckErrors <= stuckErrors + 1;
            end
         end
         else
         begin
            mismatchRun <= 0;
         end
      end
      if (!rstN)
      begin
         mSrc                <= 0;
         mLeft               <= 0;
         mDisplay.digitHigh  <= postPkg::SegReset;   // dash + dp
         mDisplay.digitLow   <= postPkg::SegReset;
         primed              <= 1;
      end
      else
      begin
         if (mSrc != 0)
         begin
            code     = codeFor(errorCodes, mSrc);    // live faults
            mDisplay <= {postPkg::SegTable[code[7:4]], postPkg::SegTable[code[3:0]]};
         end
         if (mSrc == 0 || mLeft == 1)                // idle or last dwell cycle
         begin
            nxt = nextFailing(errorCodes, mSrc);
            mSrc  <= nxt;
            mLeft <= dwellCycles;
            if (mSrc != 0 && nxt == 0)
            begin
               rounds <= rounds + 1;                 // round over
            end
         end
         else
         begin
            mLeft <= mLeft - 1;
         end
      end
   end

endmodule

// ==== bench/postTb.sv ====
// testbench top: clock, reset, seeded random stimulus, dut, checker, timeout and report
`timescale 1ns/10ps

module postTb;

   localparam int Dwell      = 20;                   // short dwell for sim
   localparam int NumTests   = 12;
   localparam int RoundLen   = 6 * Dwell + 2;        // idle + six dwells + slack
   localparam int CycleLimit = (NumTests + 2) * 3 * RoundLen + 200;

   logic                iClk;
   logic                rstN;
   postPkg::errorCodesT errorCodes;
   postPkg::seqFailT    seqFail;
   postPkg::segPairT    display;
   int                  valueErrors;
   int                  stuckErrors;
   int                  rounds;
   int                  cycles;

   postTop #(.dwellCycles(32'(Dwell))) i_dut (
      .iClk       (iClk),
      .rstN       (rstN),
      .errorCodes (errorCodes),
      .seqFail    (seqFail),
      .display    (display)
   );

   postChecker #(.dwellCycles(Dwell)) uChecker (
      .iClk        (iClk),
      .rstN        (rstN),
      .errorCodes  (errorCodes),
      .seqFail     (seqFail),
      .display     (display),
      .valueErrors (valueErrors),
      .stuckErrors (stuckErrors),
      .rounds      (rounds)
   );

   initial
   begin
      iClk = 1'b0;
      forever #5 iClk = ~iClk;                       // 10 ns period
   end

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   // zero, timer only with empty mask, or any nonzero word
   function automatic logic [8:0] pickWord(int width);
      logic [8:0] full;
      int         kind;
      full = 9'((1 << width) - 1);
      kind = int'($urandom % 4);
      if (kind == 0)
      begin
         return 9'd0;
      end
      else if (kind == 1)
      begin
         return 9'(1 << (width - 1));
      end
      return 9'(($urandom % 32'(full)) + 32'd1);
   endfunction

   function automatic postPkg::errorCodesT makeCodes(bit single);
      postPkg::errorCodesT c;
      int                  keep;
      c.bmc  = 5'(pickWord(5));
      c.pch  = 4'(pickWord(4));
      c.psu  = 3'(pickWord(3));
      c.cpu0 = 8'(pickWord(8));
      c.cpu1 = 8'(pickWord(8));
      c.mem  = pickWord(9);
      if (single)                                    // single source test
      begin
         keep   = int'($urandom % 6);
         c.bmc  = (keep == 0) ? c.bmc : '0;
         c.pch  = (keep == 1) ? c.pch : '0;
         c.psu  = (keep == 2) ? c.psu : '0;
         c.cpu0 = (keep == 3) ? c.cpu0 : '0;
         c.cpu1 = (keep == 4) ? c.cpu1 : '0;
         c.mem  = (keep == 5) ? c.mem : '0;
      end
      if (c == '0)
      begin
         c.mem = 9'h001;                             // keep the rotation running
      end
      return c;
   endfunction

   task automatic waitRounds(int n);
      int start;
      start = rounds;
      while (rounds - start < n)
      begin
         @(posedge iClk);
      end
   endtask

   task automatic printCounts();
      $display("errors: values %0d, stuck %0d", valueErrors, stuckErrors);
   endtask

   //////////////////////////////
   // run limit
   //////////////////////////////

   initial cycles = 0;

   always @(posedge iClk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CycleLimit)
      begin
         $display("timeout: run did not finish within %0d cycles", CycleLimit);
         printCounts();
         $display("tests failed");
         $finish;
      end
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial
   begin
      void'($urandom(46));                           // fixed seed
      rstN       = 1'b0;
      errorCodes = '0;
      repeat (4) @(posedge iClk);
      rstN <= 1'b1;
      repeat (3) @(posedge iClk);                    // idle, dashes shown
      for (int t = 0; t < NumTests; t++)
      begin
         @(posedge iClk);
         errorCodes <= makeCodes(t % 3 == 0);        // every third test one source
         waitRounds(3);
      end
      @(posedge iClk);
      errorCodes <= makeCodes(1'b0);                 // clearing test
      waitRounds(1);
      repeat (Dwell / 2) @(posedge iClk);            // mid dwell
      errorCodes <= '0;
      waitRounds(1);
      repeat (2 * Dwell) @(posedge iClk);            // display must hold
      printCounts();
      if (valueErrors == 0 && stuckErrors == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== list.f ====
verilog/postPkg.sv
verilog/faultCollect.sv
verilog/postFsm.sv
verilog/dwellTimer.sv
verilog/codeLookup.sv
verilog/segEncode.sv
verilog/postTop.sv
bench/postChecker.sv
bench/postTb.sv

// ==== verilog/codeLookup.sv ====
// code lookup: turns the displayed source's fault word into an 8-bit post code
`timescale 1ns/10ps

module codeLookup (
   input  postPkg::faultArrayT faults,
   input  postPkg::sourceIdT   curSource,
   output logic [7:0]          postCode              // don't care in Idle
);

   logic [2:0]         slot;                         // faults index of curSource
   postPkg::faultWordT word;                         // selected fault word
   logic [2:0]         idx;                          // lowest failed rail
   logic [7:0]         base;

   //////////////////////////////
   // select word
   //////////////////////////////

   // Idle maps to slot 0, the result is not used there
   assign slot = (curSource == postPkg::Idle) ? 3'd0 : 3'(curSource) - 3'd1;
   assign word = faults[slot];

   //////////////////////////////
   // lowest set rail
   //////////////////////////////

   always_comb
   begin
      idx = 3'd0;                                    // empty mask gives rail 0
      for (int i = 7; i >= 0; i--)
      begin
         if (word.vrMask[i])
         begin
            idx = 3'(i);                             // last hit = lowest bit
         end
      end
   end

   //////////////////////////////
   // base + stride
   //////////////////////////////

   // timer faults use their own base
   assign base = word.isTimer ? postPkg::TimerBase[slot] : postPkg::PgBase[slot];

   // cpu codes interleave, hence stride 2 there
   assign postCode = base + 8'(idx) * postPkg::CodeStride[slot];

endmodule

// ==== verilog/dwellTimer.sv ====
// dwell timer: counts cycles from each restart and flags the last cycle of the dwell
`timescale 1ns/10ps

module dwellTimer #(
   parameter logic [31:0] dwellCycles = postPkg::DwellCycles   // cycles per source
) (
   input  logic iClk,
   input  logic rstN,
   input  logic dwellRestart,                        // first cycle of a source
   output logic dwellDone                            // last cycle of dwell
);

   logic [31:0] count;                               // registered count
   logic [31:0] countNow;                            // count seen this cycle

   assign countNow  = dwellRestart ? 32'd0 : count;  // restart cycle reads as zero
   assign dwellDone = (countNow == dwellCycles - 32'd1);

   always_ff @(posedge iClk)
   begin
      if (!rstN)
      begin
         count <= 32'd0;
      end
      else if (!dwellDone)
      begin
         count <= countNow + 32'd1;
      end
      else
      begin
         count <= countNow;                          // saturate at terminal count
      end
   end

endmodule

// ==== verilog/faultCollect.sv ====
// fault collector: splits raw words into uniform fault words and forms fail flags
`timescale 1ns/10ps

module faultCollect (
   input  postPkg::errorCodesT               errorCodes,
   output postPkg::faultArrayT               faults,   // one word per source
   output logic [postPkg::NumSources-1:0]    srcFail,  // bit 0 = bmc
   output postPkg::seqFailT                  seqFail
);

   //////////////////////////////
   // normalize words
   //////////////////////////////

   // msb goes to isTimer, rest zero extended
   assign faults[0].isTimer = errorCodes.bmc[4];
   assign faults[0].vrMask  = 8'(errorCodes.bmc[3:0]);
   assign faults[1].isTimer = errorCodes.pch[3];
   assign faults[1].vrMask  = 8'(errorCodes.pch[2:0]);
   assign faults[2].isTimer = errorCodes.psu[2];
   assign faults[2].vrMask  = 8'(errorCodes.psu[1:0]);
   assign faults[3].isTimer = errorCodes.cpu0[7];
   assign faults[3].vrMask  = 8'(errorCodes.cpu0[6:0]);
   assign faults[4].isTimer = errorCodes.cpu1[7];
   assign faults[4].vrMask  = 8'(errorCodes.cpu1[6:0]);
   assign faults[5].isTimer = errorCodes.mem[8];   // mem uses the full 8-bit mask
   assign faults[5].vrMask  = errorCodes.mem[7:0];

   //////////////////////////////
   // fail flags
   //////////////////////////////

   assign srcFail[0] = |errorCodes.bmc;              // any bit set = failed
   assign srcFail[1] = |errorCodes.pch;
   assign srcFail[2] = |errorCodes.psu;
   assign srcFail[3] = |errorCodes.cpu0;
   assign srcFail[4] = |errorCodes.cpu1;
   assign srcFail[5] = |errorCodes.mem;

   assign seqFail.bmc    = srcFail[0];
   assign seqFail.pch    = srcFail[1];
   assign seqFail.psu    = srcFail[2];
   assign seqFail.cpuMem = srcFail[3] | srcFail[4] | srcFail[5];   // merged for master seq

endmodule

// ==== verilog/postFsm.sv ====
// rotation fsm: picks which failing source is on the display and when to move on
`timescale 1ns/10ps

module postFsm (
   input  logic                            iClk,
   input  logic                            rstN,
   input  logic [postPkg::NumSources-1:0]  srcFail,      // bit i = source i+1
   input  logic                            dwellDone,    // current dwell over
   output postPkg::sourceIdT               curSource,
   output logic                            dwellRestart  // one cycle on entry
);

   postPkg::sourceIdT nextSrc;                       // lowest failing above current
   logic              step;                          // take nextSrc this edge

   //////////////////////////////
   // next source search
   //////////////////////////////

   // source ids are slot + 1, so slots >= curSource lie above it
   // from Idle this covers every slot
   always_comb
   begin
      nextSrc = postPkg::Idle;                       // nothing left, back to idle
      for (int i = postPkg::NumSources - 1; i >= 0; i--)
      begin
         if (srcFail[i] && (i >= int'(curSource)))
         begin
            nextSrc = postPkg::sourceIdT'(3'(i + 1)); // downward loop, lowest wins
         end
      end
   end

   // idle re-evaluates every cycle, a source only at end of dwell
   always_comb
   begin
      if (curSource == postPkg::Idle)
      begin
         step = 1'b1;
      end
      else
      begin
         step = dwellDone;
      end
   end

   //////////////////////////////
   // state register
   //////////////////////////////

   always_ff @(posedge iClk)
   begin
      if (!rstN)
      begin
         curSource    <= postPkg::Idle;
         dwellRestart <= 1'b0;
      end
      else
      begin
         dwellRestart <= step && (nextSrc != postPkg::Idle);   // pulse on source entry
         if (step)
         begin
            curSource <= nextSrc;                    // idle->idle when no faults
         end
      end
   end

endmodule

// ==== verilog/postPkg.sv ====
// post-code package with source ids, fault word types, code bases, strides and dwell constant
package postPkg;

   //////////////////////////////
   // sources
   //////////////////////////////

   localparam int NumSources = 6;                     // bmc, pch, psu, cpu0, cpu1, mem

   // idle lowest, then sources in priority order
   typedef enum logic [2:0] {
      Idle,
      Bmc,
      Pch,
      Psu,
      Cpu0,
      Cpu1,
      Mem
   } sourceIdT;

   //////////////////////////////
   // fault words
   //////////////////////////////

   // raw sequencer words, msb of each is the timer flag
   typedef struct packed {
      logic [4:0] bmc;                                // 4 vrs
      logic [3:0] pch;                                // 3 vrs
      logic [2:0] psu;                                // psu + main
      logic [7:0] cpu0;                               // 7 vrs
      logic [7:0] cpu1;                               // 7 vrs
      logic [8:0] mem;                                // 8 pwrgd_fail lines
   } errorCodesT;

   typedef struct packed {
      logic       isTimer;                            // set = rail never came up
      logic [7:0] vrMask;                             // failed rails, zero extended
   } faultWordT;

   typedef faultWordT [NumSources-1:0] faultArrayT;   // slot 0 is bmc ... slot 5 is mem

   // flags to master sequencer
   typedef struct packed {
      logic bmc;
      logic pch;
      logic psu;
      logic cpuMem;                                   // cpu0 | cpu1 | mem
   } seqFailT;

   typedef struct packed {
      logic [7:0] digitHigh;                          // active low, bit 7 = dp
      logic [7:0] digitLow;
   } segPairT;

   //////////////////////////////
   // post code tables
   //////////////////////////////

   // indexed by slot, bmc first
   localparam logic [7:0] PgBase    [0:NumSources-1] = '{8'h01, 8'h05, 8'h08, 8'h0A, 8'h0B, 8'h18};
   localparam logic [7:0] TimerBase [0:NumSources-1] = '{8'h20, 8'h24, 8'h27, 8'h29, 8'h2A, 8'h37};
   localparam logic [7:0] CodeStride[0:NumSources-1] = '{8'd1, 8'd1, 8'd1, 8'd2, 8'd2, 8'd1};

   // hex digit to segments, dp lit
   localparam logic [7:0] SegTable[0:15] = '{
      8'h40, 8'h79, 8'h24, 8'h30, 8'h19, 8'h12, 8'h02, 8'h78,
      8'h00, 8'h10, 8'h08, 8'h03, 8'h46, 8'h21, 8'h06, 8'h0E
   };

   localparam logic [7:0] SegReset = 8'hBF;           // dash + dp

   localparam logic [31:0] DwellCycles = 32'd2000000; // 1 s at 2 MHz

endpackage

// ==== verilog/postTop.sv ====
// post-code top: fault collector, rotation fsm, dwell timer, code lookup, segment driver
`timescale 1ns/10ps

module postTop #(
   parameter logic [31:0] dwellCycles = postPkg::DwellCycles   // shortened in sim
) (
   input  logic                iClk,
   input  logic                rstN,                 // sync, active low
   input  postPkg::errorCodesT errorCodes,           // raw sequencer words
   output postPkg::seqFailT    seqFail,              // to master sequencer
   output postPkg::segPairT    display               // two 7-seg digits
);

   postPkg::faultArrayT          faults;             // normalized words
   logic [postPkg::NumSources-1:0] srcFail;          // per source fail bit
   postPkg::sourceIdT            curSource;          // source on display
   logic                         dwellRestart;       // new source entered
   logic                         dwellDone;          // dwell elapsed
   logic [7:0]                   postCode;           // code of curSource

   faultCollect uFaultCollect (
      .errorCodes (errorCodes),
      .faults     (faults),
      .srcFail    (srcFail),
      .seqFail    (seqFail)
   );

   postFsm uPostFsm (
      .iClk         (iClk),
      .rstN         (rstN),
      .srcFail      (srcFail),
      .dwellDone    (dwellDone),
      .curSource    (curSource),
      .dwellRestart (dwellRestart)
   );

   dwellTimer #(.dwellCycles(dwellCycles)) uDwellTimer (
      .iClk         (iClk),
      .rstN         (rstN),
      .dwellRestart (dwellRestart),
      .dwellDone    (dwellDone)
   );

   codeLookup uCodeLookup (
      .faults    (faults),
      .curSource (curSource),
      .postCode  (postCode)
   );

   segEncode uSegEncode (
      .iClk      (iClk),
      .rstN      (rstN),
      .curSource (curSource),
      .postCode  (postCode),
      .display   (display)
   );

endmodule

// ==== verilog/segEncode.sv ====
// segment driver: registers both seven-segment digits from the post code
`timescale 1ns/10ps

module segEncode (
   input  logic              iClk,
   input  logic              rstN,
   input  postPkg::sourceIdT curSource,              // Idle = hold
   input  logic [7:0]        postCode,
   output postPkg::segPairT  display                 // active low, dp lit
);

   postPkg::segPairT nextDisplay;                    // patterns for this code

   //////////////////////////////
   // nibble decode
   //////////////////////////////

   assign nextDisplay.digitHigh = postPkg::SegTable[postCode[7:4]];   // upper hex digit
   assign nextDisplay.digitLow  = postPkg::SegTable[postCode[3:0]];   // lower hex digit

   //////////////////////////////
   // digit registers
   //////////////////////////////

   // a source is shown one cycle after the state changes
   // Idle keeps the last code on the digits
   always_ff @(posedge iClk)
   begin
      if (!rstN)
      begin
         display.digitHigh <= postPkg::SegReset;     // .- on both digits
         display.digitLow  <= postPkg::SegReset;
      end
      else if (curSource != postPkg::Idle)
      begin
         display <= nextDisplay;
      end
   end

endmodule
